/* verilog/vproc_pkg.sv */
/* Vector coprocessor package
   Widths, lane count, instruction fields, lane op codes and writeback control */
package vproc_pkg;

    localparam int XLEN      = 32;  // Scalar and instruction width
    localparam int ELEN      = 32;  // Fixed element width
    localparam int NUM_LANES = 4;   // Element lanes, also the fixed vl
    localparam int NUM_VREGS = 32;

    typedef logic [XLEN-1:0]           word_t;
    typedef logic [ELEN-1:0]           elem_t;
    typedef logic [NUM_LANES*ELEN-1:0] vreg_t;      // Element i at [i*ELEN +: ELEN]
    typedef logic [4:0]                vreg_addr_t;
    typedef logic [NUM_LANES-1:0]      lane_mask_t;
    typedef logic [3:0]                lane_op_t;

    // Major opcode and funct3 forms
    localparam logic [6:0] OPC_VECTOR = 7'b1010111;
    localparam logic [2:0] F3_OPIVV   = 3'b000;
    localparam logic [2:0] F3_OPMVV   = 3'b010;
    localparam logic [2:0] F3_OPIVI   = 3'b011;
    localparam logic [2:0] F3_OPIVX   = 3'b100;

    // funct6 of the integer ops kept
    localparam logic [5:0] F6_VADD  = 6'b000000;
    localparam logic [5:0] F6_VSUB  = 6'b000010;
    localparam logic [5:0] F6_VRSUB = 6'b000011;
    localparam logic [5:0] F6_VMINU = 6'b000100;
    localparam logic [5:0] F6_VMIN  = 6'b000101;
    localparam logic [5:0] F6_VMAXU = 6'b000110;
    localparam logic [5:0] F6_VMAX  = 6'b000111;
    localparam logic [5:0] F6_VAND  = 6'b001001;
    localparam logic [5:0] F6_VOR   = 6'b001010;
    localparam logic [5:0] F6_VXOR  = 6'b001011;
    localparam logic [5:0] F6_VMV   = 6'b010111;  // vmv.v.*, vs2 must be v0
    localparam logic [5:0] F6_VSLL  = 6'b100101;
    localparam logic [5:0] F6_VSRL  = 6'b101000;
    localparam logic [5:0] F6_VSRA  = 6'b101001;
    // OPMVV space
    localparam logic [5:0] F6_VREDSUM   = 6'b000000;
    localparam logic [5:0] F6_VWXUNARY0 = 6'b010000;  // vmv.x.s when vs1 is 0

    // Lane operations
    localparam lane_op_t LOP_NOP    = 4'd0;
    localparam lane_op_t LOP_ADD    = 4'd1;
    localparam lane_op_t LOP_SUB    = 4'd2;
    localparam lane_op_t LOP_RSUB   = 4'd3;
    localparam lane_op_t LOP_AND    = 4'd4;
    localparam lane_op_t LOP_OR     = 4'd5;
    localparam lane_op_t LOP_XOR    = 4'd6;
    localparam lane_op_t LOP_MINU   = 4'd7;
    localparam lane_op_t LOP_MIN    = 4'd8;
    localparam lane_op_t LOP_MAXU   = 4'd9;
    localparam lane_op_t LOP_MAX    = 4'd10;
    localparam lane_op_t LOP_SLL    = 4'd11;
    localparam lane_op_t LOP_SRL    = 4'd12;
    localparam lane_op_t LOP_SRA    = 4'd13;
    localparam lane_op_t LOP_PASS_B = 4'd14;

    typedef struct packed {
        logic       legal;      // Drives is_vec
        logic       wr_reg;     // Write vd
        logic       to_scalar;  // Return element 0 as scalar_result
        logic       reduce;     // Sum lanes into element 0
        vreg_addr_t vd;
    } wb_ctrl_t;

endpackage

/* verilog/vproc_lane_if.sv */
/* One element lane link
   Dispatch issues op and operands, the lane returns a registered result */
`timescale 1ns/1ns

interface vproc_lane_if;
    import vproc_pkg::*;

    logic     op_valid;   // One cycle per issued instruction
    lane_op_t op;
    elem_t    a;          // vs2 element
    elem_t    b;          // vs1 element, scalar or immediate
    logic     res_valid;  // One cycle after op_valid
    elem_t    res;

    modport dispatch (
        output op_valid, op, a, b
    );

    modport lane (
        input  op_valid, op, a, b,
        output res_valid, res
    );

    modport writeback (
        input res_valid, res
    );

endinterface

/* verilog/vproc_inst_queue.sv */
/* Two-entry instruction and operand queue
   Empty queue shows the incoming instruction straight to dispatch */
`timescale 1ns/1ns

module vproc_inst_queue (
    input  logic            clk,
    input  logic            reset,
    input  logic            inst_valid,
    input  vproc_pkg::word_t instruction,
    input  vproc_pkg::word_t rs1_data,
    input  vproc_pkg::word_t rs2_data,
    output logic            vec_pro_ready,
    output logic            q_valid,
    output vproc_pkg::word_t q_inst,
    output vproc_pkg::word_t q_rs1,
    output vproc_pkg::word_t q_rs2,
    input  logic            q_pop
);
    import vproc_pkg::*;

    word_t      inst_mem [2];
    word_t      rs1_mem  [2];
    word_t      rs2_mem  [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;      // 0, 1 or 2 entries
    logic       empty;
    logic       push;
    logic       do_write;
    logic       do_read;

    assign empty         = (count == 2'd0);
    assign vec_pro_ready = (count != 2'd2);        // Not full
    assign push          = inst_valid & vec_pro_ready;
    assign q_valid       = ~empty | inst_valid;

    // Bypass path when nothing is stored
    assign q_inst = empty ? instruction : inst_mem[rd_ptr];
    assign q_rs1  = empty ? rs1_data    : rs1_mem[rd_ptr];
    assign q_rs2  = empty ? rs2_data    : rs2_mem[rd_ptr];

    assign do_write = push & ~(empty & q_pop);     // Bypassed entry is never stored
    assign do_read  = q_pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_write) begin
            inst_mem[wr_ptr] <= instruction;
            rs1_mem[wr_ptr]  <= rs1_data;
            rs2_mem[wr_ptr]  <= rs2_data;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (do_write) wr_ptr <= ~wr_ptr;       // Wraps over two slots
            if (do_read)  rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, do_write} - {1'b0, do_read};
        end
    end

endmodule

/* verilog/vproc_dispatch.sv */
/* Decode, register read and issue
   One instruction in flight, lane inputs registered on the pop edge */
`timescale 1ns/1ns

module vproc_dispatch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  q_valid,
    input  vproc_pkg::word_t      q_inst,
    input  vproc_pkg::word_t      q_rs1,
    output logic                  q_pop,
    output vproc_pkg::vreg_addr_t rd_addr_a,
    output vproc_pkg::vreg_addr_t rd_addr_b,
    input  vproc_pkg::vreg_t      rd_data_a,
    input  vproc_pkg::vreg_t      rd_data_b,
    vproc_lane_if.dispatch        lanes [vproc_pkg::NUM_LANES],
    output vproc_pkg::wb_ctrl_t   wb_ctrl,
    input  logic                  resp_done
);
    import vproc_pkg::*;

    logic [5:0] funct6;
    logic       vm;
    vreg_addr_t vs2;
    vreg_addr_t vs1;         // Also rs1 index and imm5
    logic [2:0] funct3;
    vreg_addr_t vd;
    logic [6:0] opcode;
    logic       is_vv, is_vx, is_vi, is_mvv, vec_ok;
    logic [2:0] forms;       // Allowed {vi, vx, vv}
    lane_op_t   opi_op;
    logic       opi_ok, is_red, is_mvxs, legal, is_shift;
    word_t      scal;        // rs1 or immediate operand
    logic       busy;

    assign {funct6, vm, vs2, vs1, funct3, vd, opcode} = q_inst;

    assign rd_addr_a = vs2;
    assign rd_addr_b = vs1;

    assign vec_ok = (opcode == OPC_VECTOR) & vm;   // Masked forms are illegal
    assign is_vv  = (funct3 == F3_OPIVV);
    assign is_vx  = (funct3 == F3_OPIVX);
    assign is_vi  = (funct3 == F3_OPIVI);
    assign is_mvv = (funct3 == F3_OPMVV);

    always_comb begin
        opi_op = LOP_NOP;
        case (funct6)
            F6_VADD:  opi_op = LOP_ADD;
            F6_VSUB:  opi_op = LOP_SUB;
            F6_VRSUB: opi_op = LOP_RSUB;
            F6_VMINU: opi_op = LOP_MINU;
            F6_VMIN:  opi_op = LOP_MIN;
            F6_VMAXU: opi_op = LOP_MAXU;
            F6_VMAX:  opi_op = LOP_MAX;
            F6_VAND:  opi_op = LOP_AND;
            F6_VOR:   opi_op = LOP_OR;
            F6_VXOR:  opi_op = LOP_XOR;
            F6_VMV:   opi_op = LOP_PASS_B;
            F6_VSLL:  opi_op = LOP_SLL;
            F6_VSRL:  opi_op = LOP_SRL;
            F6_VSRA:  opi_op = LOP_SRA;
            default:  opi_op = LOP_NOP;
        endcase
        case (funct6)
            F6_VADD, F6_VAND, F6_VOR, F6_VXOR,
            F6_VMV, F6_VSLL, F6_VSRL, F6_VSRA:     forms = 3'b111;
            F6_VSUB, F6_VMINU, F6_VMIN,
            F6_VMAXU, F6_VMAX:                     forms = 3'b011;
            F6_VRSUB:                              forms = 3'b110;  // No .vv form
            default:                               forms = 3'b000;
        endcase
    end

    assign opi_ok  = vec_ok & (|(forms & {is_vi, is_vx, is_vv}))
                     & ((funct6 != F6_VMV) | (vs2 == '0));
    assign is_red  = vec_ok & is_mvv & (funct6 == F6_VREDSUM);
    assign is_mvxs = vec_ok & is_mvv & (funct6 == F6_VWXUNARY0) & (vs1 == '0);
    assign legal   = opi_ok | is_red | is_mvxs;

    // Shift immediates are unsigned, the rest sign-extend simm5
    assign is_shift = (opi_op == LOP_SLL) | (opi_op == LOP_SRL) | (opi_op == LOP_SRA);
    assign scal = is_vx    ? q_rs1 :
                  is_shift ? word_t'(vs1) : {{(XLEN-5){vs1[4]}}, vs1};

    assign q_pop = q_valid & ~busy;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy <= 1'b0;
        end else if (q_pop) begin
            busy <= 1'b1;
        end else if (resp_done) begin
            busy <= 1'b0;      // Response taken, next pop allowed
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) wb_ctrl <= '{legal, legal & ~is_mvxs, is_mvxs, is_red, vd};
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_op_t op_n;
        elem_t    b_n;

        always_comb begin
            if (!legal)       op_n = LOP_NOP;
            else if (is_red)  op_n = (i == 0) ? LOP_ADD : LOP_PASS_B;  // Lane 0 adds vs1[0]
            else if (is_mvxs) op_n = LOP_PASS_B;
            else              op_n = opi_op;
            if (is_mvv)      b_n = (is_red && i == 0) ? rd_data_b[0 +: ELEN]
                                                      : rd_data_a[i*ELEN +: ELEN];
            else if (is_vv)  b_n = rd_data_b[i*ELEN +: ELEN];
            else             b_n = scal;
        end

        always_ff @(posedge clk or negedge reset) begin
            if (!reset) begin
                lanes[i].op_valid <= 1'b0;
            end else begin
                lanes[i].op_valid <= q_pop;
            end
        end

        always_ff @(posedge clk) begin
            if (q_pop) begin
                lanes[i].op <= op_n;
                lanes[i].a  <= rd_data_a[i*ELEN +: ELEN];
                lanes[i].b  <= b_n;
            end
        end
    end

endmodule

/* verilog/vproc_vrf.sv */
/* Vector register file
   Two asynchronous reads, one synchronous write with a per-lane mask */
`timescale 1ns/1ns

module vproc_vrf (
    input  logic                   clk,
    input  logic                   reset,
    input  vproc_pkg::vreg_addr_t  rd_addr_a,
    input  vproc_pkg::vreg_addr_t  rd_addr_b,
    output vproc_pkg::vreg_t       rd_data_a,
    output vproc_pkg::vreg_t       rd_data_b,
    input  logic                   wr_en,
    input  vproc_pkg::vreg_addr_t  wr_addr,
    input  vproc_pkg::lane_mask_t  wr_mask,
    input  vproc_pkg::vreg_t       wr_data
);
    import vproc_pkg::*;

    vreg_t regs [NUM_VREGS];

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // All registers start at zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (wr_mask[i]) regs[wr_addr][i*ELEN +: ELEN] <= wr_data[i*ELEN +: ELEN];
            end
        end
    end

endmodule

/* verilog/vproc_lane.sv */
/* Element lane
   32-bit ALU on a and b, result registered one cycle after op_valid */
`timescale 1ns/1ns

module vproc_lane (
    input  logic       clk,
    input  logic       reset,
    vproc_lane_if.lane lane
);
    import vproc_pkg::*;

    elem_t      alu;
    logic [4:0] shamt;     // Only the low 5 bits of b shift

    assign shamt = lane.b[4:0];

    always_comb begin
        case (lane.op)
            LOP_ADD:    alu = lane.a + lane.b;
            LOP_SUB:    alu = lane.a - lane.b;
            LOP_RSUB:   alu = lane.b - lane.a;                 // Reverse operands
            LOP_AND:    alu = lane.a & lane.b;
            LOP_OR:     alu = lane.a | lane.b;
            LOP_XOR:    alu = lane.a ^ lane.b;
            LOP_MINU:   alu = (lane.a < lane.b) ? lane.a : lane.b;
            LOP_MIN:    alu = ($signed(lane.a) < $signed(lane.b)) ? lane.a : lane.b;
            LOP_MAXU:   alu = (lane.a > lane.b) ? lane.a : lane.b;
            LOP_MAX:    alu = ($signed(lane.a) > $signed(lane.b)) ? lane.a : lane.b;
            LOP_SLL:    alu = lane.a << shamt;
            LOP_SRL:    alu = lane.a >> shamt;                 // Zero fill
            LOP_SRA:    alu = elem_t'($signed(lane.a) >>> shamt);  // Sign fill
            LOP_PASS_B: alu = lane.b;
            default:    alu = '0;                              // NOP
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            lane.res_valid <= 1'b0;
        end else begin
            lane.res_valid <= lane.op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lane.op_valid) lane.res <= alu;
    end

endmodule

/* verilog/vproc_writeback.sv */
/* Writeback and response
   Gathers lane results, sums reductions, writes vd and holds the ack */
`timescale 1ns/1ns

module vproc_writeback (
    input  logic                  clk,
    input  logic                  reset,
    vproc_lane_if.writeback       lanes [vproc_pkg::NUM_LANES],
    input  vproc_pkg::wb_ctrl_t   wb_ctrl,
    output logic                  wr_en,
    output vproc_pkg::vreg_addr_t wr_addr,
    output vproc_pkg::lane_mask_t wr_mask,
    output vproc_pkg::vreg_t      wr_data,
    output logic                  vec_pro_ack,
    output logic                  is_vec,
    output vproc_pkg::word_t      scalar_result,
    input  logic                  scalar_pro_ready,
    output logic                  resp_done
);
    import vproc_pkg::*;

    vreg_t      lane_res;
    lane_mask_t res_vld;
    elem_t      sum;
    logic       capture;
    logic       wr_pend;    // High for the first ack cycle only
    wb_ctrl_t   ctrl_q;
    vreg_t      res_q;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_gather
        assign lane_res[i*ELEN +: ELEN] = lanes[i].res;
        assign res_vld[i]               = lanes[i].res_valid;
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            sum = sum + lane_res[i*ELEN +: ELEN];
        end
    end

    assign capture = &res_vld;   // Lanes run in lockstep

    always_ff @(posedge clk) begin
        if (capture) begin
            ctrl_q <= wb_ctrl;
            res_q  <= wb_ctrl.reduce ? {lane_res[NUM_LANES*ELEN-1:ELEN], sum} : lane_res;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            vec_pro_ack <= 1'b0;
            wr_pend     <= 1'b0;
        end else begin
            wr_pend <= capture;
            if (capture)        vec_pro_ack <= 1'b1;
            else if (resp_done) vec_pro_ack <= 1'b0;   // Held until accepted
        end
    end

    assign wr_en   = wr_pend & ctrl_q.wr_reg;
    assign wr_addr = ctrl_q.vd;
    assign wr_mask = ctrl_q.reduce ? lane_mask_t'(1) : '1;   // Reduction writes element 0
    assign wr_data = res_q;

    assign resp_done     = vec_pro_ack & scalar_pro_ready;
    assign is_vec        = ctrl_q.legal;
    assign scalar_result = ctrl_q.to_scalar ? res_q[0 +: XLEN] : '0;

endmodule

/* verilog/vector_processor.sv */
/* Vector coprocessor top
   Queue, dispatch, register file, four lanes and writeback */
`timescale 1ns/1ns

module vector_processor (
    input  logic             clk,
    input  logic             reset,
    input  vproc_pkg::word_t instruction,
    input  vproc_pkg::word_t rs1_data,
    input  vproc_pkg::word_t rs2_data,
    input  logic             inst_valid,
    input  logic             scalar_pro_ready,
    output logic             vec_pro_ready,
    output logic             vec_pro_ack,
    output logic             is_vec,
    output vproc_pkg::word_t scalar_result
);
    import vproc_pkg::*;

    logic       q_valid;
    word_t      q_inst;
    word_t      q_rs1;
    logic       q_pop;
    vreg_addr_t rd_addr_a, rd_addr_b;
    vreg_t      rd_data_a, rd_data_b;
    wb_ctrl_t   wb_ctrl;
    logic       resp_done;
    logic       wr_en;
    vreg_addr_t wr_addr;
    lane_mask_t wr_mask;
    vreg_t      wr_data;

    vproc_lane_if lane_if [NUM_LANES] ();

    vproc_inst_queue i_queue (
        .clk, .reset, .inst_valid, .instruction, .rs1_data, .rs2_data,
        .vec_pro_ready, .q_valid, .q_inst, .q_rs1,
        .q_rs2 (),      // No kept instruction reads rs2
        .q_pop
    );

    vproc_dispatch i_dispatch (
        .clk, .reset, .q_valid, .q_inst, .q_rs1, .q_pop,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .lanes (lane_if), .wb_ctrl, .resp_done
    );

    vproc_vrf i_vrf (
        .clk, .reset, .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wr_en, .wr_addr, .wr_mask, .wr_data
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        vproc_lane i_lane (
            .clk, .reset, .lane (lane_if[i])
        );
    end

    vproc_writeback i_writeback (
        .clk, .reset, .lanes (lane_if), .wb_ctrl,
        .wr_en, .wr_addr, .wr_mask, .wr_data,
        .vec_pro_ack, .is_vec, .scalar_result, .scalar_pro_ready, .resp_done
    );

endmodule

/* dv/vproc_asserts.sv */
/* Handshake assertions for the vector coprocessor top
   Bound into vector_processor */
`timescale 1ns/1ns

module vproc_asserts (
    input logic        clk,
    input logic        reset,
    input logic        vec_pro_ack,
    input logic        scalar_pro_ready,
    input logic        is_vec,
    input logic [31:0] scalar_result
);

    // No response offered in reset
    ack_low_in_reset: assert property (@(posedge clk) !reset |-> !vec_pro_ack)
        else $error("vec_pro_ack high during reset");

    // Payload frozen until the scalar core takes it
    resp_stable: assert property (@(posedge clk) disable iff (!reset)
        vec_pro_ack && !scalar_pro_ready |=> $stable(is_vec) && $stable(scalar_result))
        else $error("response changed while waiting for scalar_pro_ready");

    ack_held: assert property (@(posedge clk) disable iff (!reset)
        vec_pro_ack && !scalar_pro_ready |=> vec_pro_ack)
        else $error("vec_pro_ack dropped before acceptance");

endmodule

bind vector_processor vproc_asserts i_asserts (
    .clk, .reset, .vec_pro_ack, .scalar_pro_ready, .is_vec, .scalar_result
);

/* dv/vproc_tb.sv */
/* Vector coprocessor testbench
   LFSR-driven instructions with random gaps and stalls, checked against an element model */
`timescale 1ns/1ns

module vproc_tb;

    localparam int NUM_INSTS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 20;   // Generous per-instruction budget
    localparam int NREGS          = 32;
    localparam int NLANES         = 4;

    // Operation picks, 0 to 13 map straight from a 5-bit draw
    localparam int OP_ADD = 0, OP_SUB = 1, OP_RSUB = 2, OP_AND = 3, OP_OR = 4, OP_XOR = 5;
    localparam int OP_MINU = 6, OP_MIN = 7, OP_MAXU = 8, OP_MAX = 9;
    localparam int OP_SLL = 10, OP_SRL = 11, OP_SRA = 12, OP_MV = 13;
    localparam int OP_REDSUM = 14, OP_MVXS = 15, OP_ILLEGAL = 16;
    localparam int FORM_VV = 0, FORM_VX = 1, FORM_VI = 2;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] instruction;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        scalar_pro_ready;
    logic        vec_pro_ready;
    logic        vec_pro_ack;
    logic        is_vec;
    logic [31:0] scalar_result;

    logic [31:0] vmodel [NREGS][NLANES];   // Reference register file
    logic [32:0] exp_q [$];                // {is_vec, scalar_result} in acceptance order
    logic [31:0] lfsr;
    int          errors;
    int          sent;
    int          accepted;
    int          resp_count;
    int          cycles;
    logic        xfer;                     // Instruction taken at the coming edge
    int          cur_op;
    int          cur_form;
    logic [4:0]  cur_vd;
    logic [4:0]  cur_vs1;
    logic [4:0]  cur_vs2;
    logic [31:0] cur_b;                    // rs1 or immediate operand

    vector_processor i_dut (
        .clk, .reset, .instruction, .rs1_data, .rs2_data, .inst_valid, .scalar_pro_ready,
        .vec_pro_ready, .vec_pro_ack, .is_vec, .scalar_result
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};          // One step per bit
        end
        return v;
    endfunction

    function automatic logic [5:0] funct6_of(input int op);
        case (op)
            OP_SUB:  return 6'b000010;
            OP_RSUB: return 6'b000011;
            OP_MINU: return 6'b000100;
            OP_MIN:  return 6'b000101;
            OP_MAXU: return 6'b000110;
            OP_MAX:  return 6'b000111;
            OP_AND:  return 6'b001001;
            OP_OR:   return 6'b001010;
            OP_XOR:  return 6'b001011;
            OP_MV:   return 6'b010111;
            OP_SLL:  return 6'b100101;
            OP_SRL:  return 6'b101000;
            OP_SRA:  return 6'b101001;
            OP_MVXS: return 6'b010000;   // VWXUNARY0
            default: return 6'b000000;   // vadd, vredsum
        endcase
    endfunction

    // Element result, a is the vs2 element
    function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        logic [4:0]  sh;
        sh = b[4:0];                        // Only the low 5 bits shift
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_RSUB: r = b - a;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_MINU: r = (a < b) ? a : b;
            OP_MIN:  r = ($signed(a) < $signed(b)) ? a : b;
            OP_MAXU: r = (a > b) ? a : b;
            OP_MAX:  r = ($signed(a) > $signed(b)) ? a : b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = a >> sh;
            OP_SRA:  r = $signed(a) >>> sh;
            default: r = b;                 // vmv.v.*
        endcase
        return r;
    endfunction

    task automatic apply_model();
        logic [31:0] sum;
        logic [31:0] res;
        logic        vec;
        res = '0;
        vec = 1'b1;
        if (cur_op == OP_MVXS) begin
            res = vmodel[cur_vs2][0];
        end else if (cur_op == OP_REDSUM) begin
            sum = vmodel[cur_vs1][0];
            for (int i = 0; i < NLANES; i++) sum = sum + vmodel[cur_vs2][i];
            vmodel[cur_vd][0] = sum;        // Upper elements of vd untouched
        end else if (cur_op == OP_ILLEGAL) begin
            vec = 1'b0;
        end else begin
            for (int i = 0; i < NLANES; i++) begin
                vmodel[cur_vd][i] = alu_model(cur_op, vmodel[cur_vs2][i],
                                              (cur_form == FORM_VV) ? vmodel[cur_vs1][i] : cur_b);
            end
        end
        exp_q.push_back({vec, res});
    endtask

    task automatic next_instruction(input int idx);
        int          pick;
        int          variant;
        logic [4:0]  imm;
        logic [4:0]  fld1;
        logic [5:0]  f6;
        logic [2:0]  f3;
        logic        vm;
        logic [6:0]  opc;
        logic [31:0] rs1;
        pick     = rand_bits(5);
        cur_vd   = 5'(rand_bits(5));
        cur_vs1  = 5'(rand_bits(5));
        cur_vs2  = 5'(rand_bits(5));
        rs1      = rand_bits(32);
        imm      = 5'(rand_bits(5));
        vm       = 1'b1;
        opc      = 7'b1010111;
        cur_form = FORM_VV;
        // Odd registers keep their reset value until a random write
        if (idx < NREGS / 2) begin          // Fill even registers by vmv.v.x first
            cur_op   = OP_MV;
            cur_form = FORM_VX;
            cur_vd   = 5'(idx * 2);
        end else if (pick < 14) begin
            cur_op   = pick;
            cur_form = rand_bits(2) % 3;
            if (cur_op == OP_RSUB && cur_form == FORM_VV) cur_form = FORM_VX;
            if (cur_op inside {OP_SUB, OP_MINU, OP_MIN, OP_MAXU, OP_MAX} && cur_form == FORM_VI)
                cur_form = FORM_VX;         // No .vi form for these
        end else if (pick < 18) cur_op = OP_REDSUM;
        else if (pick < 28) cur_op = OP_MVXS;
        else cur_op = OP_ILLEGAL;
        if (cur_op == OP_MV) cur_vs2 = '0;

        if (cur_form == FORM_VX) cur_b = rs1;
        else if (cur_op inside {OP_SLL, OP_SRL, OP_SRA}) cur_b = {27'b0, imm};   // uimm5
        else cur_b = {{27{imm[4]}}, imm};   // simm5

        f3   = (cur_form == FORM_VV) ? 3'b000 : (cur_form == FORM_VX) ? 3'b100 : 3'b011;
        fld1 = (cur_form == FORM_VI) ? imm : cur_vs1;
        f6   = funct6_of(cur_op);
        if (cur_op == OP_REDSUM || cur_op == OP_MVXS) f3 = 3'b010;   // OPMVV
        if (cur_op == OP_MVXS) fld1 = '0;
        if (cur_op == OP_ILLEGAL) begin
            variant = rand_bits(2);
            case (variant)
                0: vm = 1'b0;               // Masked vadd.vv
                1: opc = 7'b0110011;        // Scalar OP opcode
                2: begin
                    f6 = 6'b000010;         // vsub.vi
                    f3 = 3'b011;
                end
                default: f6 = 6'b000011;    // vrsub.vv
            endcase
        end
        instruction <= {f6, vm, cur_vs2, fld1, f3, cur_vd, opc};
        rs1_data    <= rs1;
        rs2_data    <= rand_bits(32);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
        end
    endtask

    // Called at the falling edge, values hold until the next rising edge
    task automatic sample_outputs();
        logic [32:0] want;
        if (vec_pro_ack && scalar_pro_ready) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: response %0d arrived with no instruction pending", resp_count);
            end else begin
                want = exp_q.pop_front();
                check_value("is_vec", {31'b0, is_vec}, {31'b0, want[32]});
                check_value("scalar_result", scalar_result, want[31:0]);
            end
        end
        xfer = inst_valid && vec_pro_ready;
        if (xfer) begin
            accepted++;
            apply_model();
        end
    endtask

    task automatic drive_inputs();
        if (!inst_valid || xfer) begin      // Payload held while not taken
            if (sent < NUM_INSTS && rand_bits(2) != 0) begin
                next_instruction(sent);
                sent++;
                inst_valid <= 1'b1;
            end else begin
                inst_valid <= 1'b0;
            end
        end
        scalar_pro_ready <= (rand_bits(2) != 0);   // Stall about one cycle in four
    endtask

    task automatic finish_run();
        $display("Errors: %0d, accepted: %0d, responses: %0d", errors, accepted, resp_count);
        if (errors == 0) $display("RESULT: PASS");
        else $display("RESULT: FAIL");
        $finish;
    endtask

    initial begin
        lfsr             = 32'd68;
        errors           = 0;
        sent             = 0;
        accepted         = 0;
        resp_count       = 0;
        xfer             = 1'b0;
        reset            = 1'b0;
        inst_valid       = 1'b0;
        instruction      = '0;
        rs1_data         = '0;
        rs2_data         = '0;
        scalar_pro_ready = 1'b0;
        for (int r = 0; r < NREGS; r++) begin
            for (int i = 0; i < NLANES; i++) vmodel[r][i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_value("vec_pro_ready", {31'b0, vec_pro_ready}, 32'd1);
        check_value("vec_pro_ack", {31'b0, vec_pro_ack}, 32'd0);
        while (resp_count < NUM_INSTS) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        repeat (10) begin                   // Catch any extra response
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            sample_outputs();
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d responses never arrived", exp_q.size());
        end
        finish_run();
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("ERROR: timeout after %0d cycles with %0d of %0d responses received",
                 cycles, resp_count, NUM_INSTS);
        finish_run();
    end

endmodule

/* src.f */
verilog/vproc_pkg.sv
verilog/vproc_lane_if.sv
verilog/vproc_inst_queue.sv
verilog/vproc_dispatch.sv
verilog/vproc_vrf.sv
verilog/vproc_lane.sv
verilog/vproc_writeback.sv
verilog/vector_processor.sv
dv/vproc_asserts.sv
dv/vproc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the vector coprocessor testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module vproc_tb -f src.f -o vproc_sim
./obj_dir/vproc_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
